// File: miniproc_debug.f
+incdir+source
source/dbg_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/tiny_core.sv
source/state_collector.sv
source/debug_controller.sv
source/debug_top.sv
sim/tb_clock.sv
sim/tb_debug_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it; exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_debug_top -f miniproc_debug.f \
	&& ./obj_dir/Vtb_debug_top \
	|| exit 1

// File: sim/tb_debug_top.sv
`timescale 1ns/100ps
`include "dbg_cfg.svh"

module tb_debug_top;

	localparam int CLKS      = `DBG_CLKS_PER_BIT;
	localparam int NBYTES    = `DBG_DUMP_BYTES;
	localparam int DUMP_WAIT = (NBYTES * 10 + 20) * CLKS;
	// Full sequence needs roughly 130k cycles
	localparam int TIMEOUT_CYCLES = 400000;

	logic           clk;
	logic           reset;
	logic           rx;
	logic           tx;
	logic [31:0]    lcg_state;
	int             cycles = 0;
	logic [7:0]     tx_q [$];
	dbg_pkg::word_t prog [`DBG_IMEM_WORDS];
	logic [7:0]     exp_dump [NBYTES];
	logic [7:0]     got_dump [NBYTES];

	// Reference model state
	dbg_pkg::word_t m_imem [`DBG_IMEM_WORDS];
	dbg_pkg::word_t m_regs [`DBG_NUM_REGS];
	dbg_pkg::word_t m_dmem [`DBG_DMEM_WORDS];
	logic [5:0]     m_pc;
	logic           m_halted;

	tb_clock u_clock (.clk(clk), .reset(reset));

	debug_top u_dut (.clk(clk), .reset(reset), .rx(rx), .tx(tx));

	//////////////////////////////////////////////////////////////////////
	// Failure reporting and checks
	//////////////////////////////////////////////////////////////////////

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("error: %s got %h expected %h", name, got, exp));
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles == TIMEOUT_CYCLES)
			stop_with_failure("timeout, the run did not finish in time");
	end

	//////////////////////////////////////////////////////////////////////
	// Random numbers and program building
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		// Upper half only since the low bits of an LCG repeat quickly
		return {16'h0000, lcg_state[31:16]};
	endfunction

	function automatic dbg_pkg::word_t encode(dbg_pkg::opcode_e op, int rd, int rs, int imm);
		dbg_pkg::instr_t w;
		w.op  = op;
		w.rd  = 3'(rd);
		w.rs  = 3'(rs);
		w.imm = 7'(imm);
		return dbg_pkg::word_t'(w);
	endfunction

	// addi, add, sub, store, load, taken beqz over one word, halt at 9
	function automatic void set_fixed_program();
		prog[0] = encode(dbg_pkg::op_addi, 1, 0, 5);
		prog[1] = encode(dbg_pkg::op_addi, 2, 0, -3);
		prog[2] = encode(dbg_pkg::op_add, 3, 1, 2);
		prog[3] = encode(dbg_pkg::op_sub, 4, 1, 2);
		prog[4] = encode(dbg_pkg::op_store, 4, 1, 3);
		prog[5] = encode(dbg_pkg::op_load, 5, 0, 8);
		prog[6] = encode(dbg_pkg::op_beqz, 0, 0, 2);
		prog[7] = encode(dbg_pkg::op_addi, 6, 0, 7);
		prog[8] = encode(dbg_pkg::op_addi, 7, 5, 1);
		prog[9] = encode(dbg_pkg::op_halt, 0, 0, 0);
	endfunction

	// Forward branches only and none past the final halt
	function automatic int make_random_program();
		dbg_pkg::opcode_e op;
		int n;
		int rd;
		int rs;
		int imm;
		n = 8 + int'(lcg() % 13);
		for (int i = 0; i < n - 1; i++) begin
			op = dbg_pkg::opcode_e'(3'(1 + lcg() % 7));
			rd = int'(lcg() % 8);
			rs = int'(lcg() % 8);
			if (op == dbg_pkg::op_beqz)
				imm = 1 + int'(lcg() % (n - 1 - i));
			else
				imm = int'(lcg() % 128);
			prog[i] = encode(op, rd, rs, imm);
		end
		prog[n - 1] = encode(dbg_pkg::op_halt, 0, 0, 0);
		return n;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model of the core
	//////////////////////////////////////////////////////////////////////

	function automatic void model_reset();
		for (int i = 0; i < `DBG_NUM_REGS; i++)
			m_regs[i] = '0;
		for (int i = 0; i < `DBG_DMEM_WORDS; i++)
			m_dmem[i] = '0;
		m_pc     = '0;
		m_halted = 1'b0;
	endfunction

	function automatic void model_step();
		dbg_pkg::instr_t ins;
		dbg_pkg::word_t  imm;
		dbg_pkg::word_t  a;
		dbg_pkg::word_t  res;
		logic [5:0]      pc_n;
		logic            wr;
		if (!m_halted) begin
			ins  = dbg_pkg::instr_t'(m_imem[m_pc]);
			imm  = {{9{ins.imm[6]}}, ins.imm};
			a    = m_regs[ins.rs];
			res  = '0;
			wr   = 1'b0;
			pc_n = m_pc + 6'd1;
			case (ins.op)
				dbg_pkg::op_halt: begin
					m_halted = 1'b1;
					pc_n     = m_pc;
				end
				dbg_pkg::op_addi: begin
					res = a + imm;
					wr  = 1'b1;
				end
				dbg_pkg::op_add: begin
					res = a + m_regs[ins.imm[2:0]];
					wr  = 1'b1;
				end
				dbg_pkg::op_sub: begin
					res = a - m_regs[ins.imm[2:0]];
					wr  = 1'b1;
				end
				dbg_pkg::op_load: begin
					res = m_dmem[4'(a + imm)];
					wr  = 1'b1;
				end
				dbg_pkg::op_store: m_dmem[4'(a + imm)] = m_regs[ins.rd];
				dbg_pkg::op_beqz: begin
					if (m_regs[ins.rd] == 16'h0000)
						pc_n = m_pc + 6'(imm);
				end
				default: ;
			endcase
			if (wr && ins.rd != 3'd0)
				m_regs[ins.rd] = res;
			m_pc = pc_n;
		end
	endfunction

	task automatic model_run();
		for (int i = 0; i < 1000 && !m_halted; i++)
			model_step();
		if (!m_halted)
			stop_with_failure("model program never reached halt");
	endtask

	function automatic void build_expected();
		exp_dump[0] = {2'b00, m_pc};
		for (int r = 0; r < `DBG_NUM_REGS; r++) begin
			exp_dump[1 + 2 * r] = m_regs[r][15:8];
			exp_dump[2 + 2 * r] = m_regs[r][7:0];
		end
		for (int m = 0; m < `DBG_DMEM_WORDS; m++) begin
			exp_dump[17 + 2 * m] = m_dmem[m][15:8];
			exp_dump[18 + 2 * m] = m_dmem[m][7:0];
		end
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Serial driver and monitor
	//////////////////////////////////////////////////////////////////////

	// 8N1, LSB first, changes 1 ns after the clock edge
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			#1;
			rx = frame[i];
			repeat (CLKS - 1) @(posedge clk);
		end
	endtask

	initial begin : tx_monitor
		logic [7:0] b;
		wait (reset === 1'b0);
		forever begin
			@(negedge clk);
			if (tx !== 1'b0 && tx !== 1'b1)
				stop_with_failure("tx line is unknown after reset");
			if (tx === 1'b0) begin
				repeat (CLKS / 2) @(negedge clk);
				if (tx !== 1'b0)
					stop_with_failure("start bit on tx was too short");
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS) @(negedge clk);
					b[i] = tx;
				end
				repeat (CLKS) @(negedge clk);
				if (tx !== 1'b1)
					stop_with_failure("missing stop bit on tx");
				tx_q.push_back(b);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Command helpers
	//////////////////////////////////////////////////////////////////////

	task automatic load_program(input int n);
		send_byte(dbg_pkg::CMD_PROG);
		send_byte(8'(n));
		for (int i = 0; i < n; i++) begin
			send_byte(prog[i][15:8]);
			send_byte(prog[i][7:0]);
			m_imem[i] = prog[i];
		end
		model_reset();
	endtask

	task automatic dump_and_check();
		int waited;
		if (tx_q.size() != 0)
			stop_with_failure("unit sent bytes outside of a dump");
		build_expected();
		send_byte(dbg_pkg::CMD_DUMP);
		waited = 0;
		while (tx_q.size() < NBYTES && waited < DUMP_WAIT) begin
			@(posedge clk);
			waited++;
		end
		if (tx_q.size() < NBYTES)
			stop_with_failure($sformatf("dump ended early with %0d of %0d bytes",
				tx_q.size(), NBYTES));
		for (int i = 0; i < NBYTES; i++) begin
			got_dump[i] = tx_q.pop_front();
			check($sformatf("dump[%0d]", i), {8'h00, got_dump[i]}, {8'h00, exp_dump[i]});
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin : main_seq
		int n;
		rx        = 1'b1;
		lcg_state = 32'd40;
		wait (reset === 1'b0);
		repeat (4) @(posedge clk);

		// Fixed program run to halt
		set_fixed_program();
		load_program(10);
		send_byte(dbg_pkg::CMD_RUN);
		model_run();
		dump_and_check();

		// Run and step on a halted core change nothing
		send_byte(dbg_pkg::CMD_RUN);
		send_byte(dbg_pkg::CMD_STEP);
		dump_and_check();

		// Unknown command in idle
		send_byte(8'h58);
		dump_and_check();

		// Reload, then three single steps
		load_program(10);
		for (int i = 0; i < 3; i++) begin
			send_byte(dbg_pkg::CMD_STEP);
			model_step();
		end
		dump_and_check();

		// Random programs where each load clears the previous state
		for (int p = 0; p < 5; p++) begin
			n = make_random_program();
			load_program(n);
			send_byte(dbg_pkg::CMD_RUN);
			model_run();
			dump_and_check();
		end

		repeat (20 * CLKS) @(posedge clk);
		if (tx_q.size() != 0) begin
			stop_with_failure("unit sent bytes after the last dump");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic reset
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Reset held for 8 rising edges
	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

// File: source/debug_top.sv
`timescale 1ns/100ps

module debug_top (
	input  logic clk,
	input  logic reset,
	input  logic rx,
	output logic tx
);

	logic [7:0]           rx_byte;
	logic [7:0]           tx_byte;
	logic [7:0]           dump_byte;
	logic                 rx_done;
	logic                 tx_start;
	logic                 tx_done;
	logic                 halted;
	logic                 restart;
	logic                 next;
	logic                 last;
	dbg_pkg::core_ctrl_t  ctrl;
	dbg_pkg::state_rd_t   rd;
	dbg_pkg::state_data_t state;

	// Serial link
	uart_rx u_uart_rx (
		.clk(clk), .reset(reset), .rx(rx),
		.rx_byte(rx_byte), .rx_done(rx_done)
	);

	uart_tx u_uart_tx (
		.clk(clk), .reset(reset), .tx_start(tx_start),
		.tx_byte(tx_byte), .tx(tx), .tx_done(tx_done)
	);

	debug_controller u_debug_controller (
		.clk(clk), .reset(reset),
		.rx_byte(rx_byte), .rx_done(rx_done), .tx_done(tx_done),
		.tx_byte(tx_byte), .tx_start(tx_start), .halted(halted), .ctrl(ctrl),
		.restart(restart), .next(next), .dump_byte(dump_byte), .last(last)
	);

	state_collector u_state_collector (
		.clk(clk), .reset(reset), .restart(restart), .next(next),
		.rd(rd), .state(state), .dump_byte(dump_byte), .last(last)
	);

	// Core runs on the system clock, gated by run_en and step
	tiny_core u_tiny_core (
		.clk(clk), .reset(reset), .ctrl(ctrl),
		.rd(rd), .state(state), .halted(halted)
	);

endmodule

// File: source/debug_controller.sv
`timescale 1ns/100ps

module debug_controller (
	input  logic                clk,
	input  logic                reset,
	input  logic [7:0]          rx_byte,
	input  logic                rx_done,
	input  logic                tx_done,
	output logic [7:0]          tx_byte,
	output logic                tx_start,
	input  logic                halted,
	output dbg_pkg::core_ctrl_t ctrl,
	output logic                restart,
	output logic                next,
	input  logic [7:0]          dump_byte,
	input  logic                last
);

	typedef enum logic [2:0] {
		st_idle,
		st_prog_count,
		st_prog_hi,
		st_prog_lo,
		st_running,
		st_dump_send,
		st_dump_wait
	} dbg_state_e;

	dbg_state_e st;
	logic [7:0] words_left;
	logic [5:0] addr;

	//////////////////////////////////////////////////////////////////////
	// Collector index moves on the same edge the FSM changes state
	//////////////////////////////////////////////////////////////////////

	assign restart = (st == st_idle) && rx_done && (rx_byte == dbg_pkg::CMD_DUMP);
	assign next    = (st == st_dump_wait) && tx_done && !last;

	//////////////////////////////////////////////////////////////////////
	// Command FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		ctrl.step       <= 1'b0;
		ctrl.core_reset <= 1'b0;
		ctrl.prog_we    <= 1'b0;
		tx_start        <= 1'b0;
		if (reset) begin
			st          <= st_idle;
			ctrl.run_en <= 1'b0;
		end else begin
			case (st)
				st_idle: begin
					if (rx_done) begin
						case (rx_byte)
							dbg_pkg::CMD_PROG: st <= st_prog_count;
							dbg_pkg::CMD_RUN: begin
								if (!halted) begin
									ctrl.run_en <= 1'b1;
									st          <= st_running;
								end
							end
							dbg_pkg::CMD_STEP: ctrl.step <= !halted;
							dbg_pkg::CMD_DUMP: st <= st_dump_send;
							default: ;
						endcase
					end
				end
				st_prog_count: begin
					if (rx_done) begin
						words_left <= rx_byte;
						addr       <= '0;
						if (rx_byte == 8'd0) begin
							// Empty load still restarts the core
							ctrl.core_reset <= 1'b1;
							st              <= st_idle;
						end else begin
							st <= st_prog_hi;
						end
					end
				end
				st_prog_hi: begin
					if (rx_done) begin
						ctrl.prog_word[15:8] <= rx_byte;
						st                   <= st_prog_lo;
					end
				end
				st_prog_lo: begin
					if (rx_done) begin
						ctrl.prog_word[7:0] <= rx_byte;
						ctrl.prog_addr      <= addr;
						ctrl.prog_we        <= 1'b1;
						addr                <= addr + 6'd1;
						words_left          <= words_left - 8'd1;
						if (words_left == 8'd1) begin
							ctrl.core_reset <= 1'b1;
							st              <= st_idle;
						end else begin
							st <= st_prog_hi;
						end
					end
				end
				// Host bytes are ignored until the core halts
				st_running: begin
					if (halted) begin
						ctrl.run_en <= 1'b0;
						st          <= st_idle;
					end
				end
				st_dump_send: begin
					tx_byte  <= dump_byte;
					tx_start <= 1'b1;
					st       <= st_dump_wait;
				end
				default: begin
					if (tx_done)
						st <= last ? st_idle : st_dump_send;
				end
			endcase
		end
	end

endmodule

// File: source/state_collector.sv
`timescale 1ns/100ps
`include "dbg_cfg.svh"

module state_collector (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 restart,
	input  logic                 next,
	output dbg_pkg::state_rd_t   rd,
	input  dbg_pkg::state_data_t state,
	output logic [7:0]           dump_byte,
	output logic                 last
);

	logic [5:0] idx;
	logic [5:0] reg_pos;
	logic [5:0] mem_pos;

	always_ff @(posedge clk) begin
		if (reset || restart)
			idx <= '0;
		else if (next)
			idx <= idx + 6'd1;
	end

	// Byte offsets inside the register and memory sections
	assign reg_pos     = idx - 6'd1;
	assign mem_pos     = idx - 6'd17;
	assign rd.reg_addr = reg_pos[3:1];
	assign rd.mem_addr = mem_pos[4:1];

	always_comb begin
		if (idx == 6'd0)
			dump_byte = {2'b00, state.pc};
		else if (idx <= 6'd16)
			dump_byte = reg_pos[0] ? state.reg_word[7:0] : state.reg_word[15:8];
		else
			dump_byte = mem_pos[0] ? state.mem_word[7:0] : state.mem_word[15:8];
	end

	assign last = (idx == 6'(`DBG_DUMP_BYTES - 1));

	no_next_past_end: assert property (@(posedge clk) disable iff (reset) last |-> !next);

endmodule

// File: source/tiny_core.sv
`timescale 1ns/100ps
`include "dbg_cfg.svh"

module tiny_core (
	input  logic                 clk,
	input  logic                 reset,
	input  dbg_pkg::core_ctrl_t  ctrl,
	input  dbg_pkg::state_rd_t   rd,
	output dbg_pkg::state_data_t state,
	output logic                 halted
);

	dbg_pkg::word_t  imem [`DBG_IMEM_WORDS];
	dbg_pkg::word_t  regs [`DBG_NUM_REGS];
	dbg_pkg::word_t  dmem [`DBG_DMEM_WORDS];

	logic [5:0]      pc;
	logic [5:0]      pc_next;
	dbg_pkg::instr_t instr;
	dbg_pkg::word_t  imm_ext;
	dbg_pkg::word_t  src;
	dbg_pkg::word_t  rt_val;
	dbg_pkg::word_t  rd_val;
	dbg_pkg::word_t  wb_data;
	logic [3:0]      mem_addr;
	logic            wb_en;
	logic            exec;

	//////////////////////////////////////////////////////////////////////
	// Fetch and decode
	//////////////////////////////////////////////////////////////////////

	assign instr    = dbg_pkg::instr_t'(imem[pc]);
	assign imm_ext  = {{9{instr.imm[6]}}, instr.imm};
	assign src      = regs[instr.rs];
	assign rt_val   = regs[instr.imm[2:0]];
	assign rd_val   = regs[instr.rd];
	assign mem_addr = src[3:0] + imm_ext[3:0];
	assign exec     = (ctrl.run_en || ctrl.step) && !halted;

	always_comb begin
		wb_en   = 1'b0;
		wb_data = src + imm_ext;
		pc_next = pc + 6'd1;
		case (instr.op)
			dbg_pkg::op_addi: wb_en = 1'b1;
			dbg_pkg::op_add: begin
				wb_en   = 1'b1;
				wb_data = src + rt_val;
			end
			dbg_pkg::op_sub: begin
				wb_en   = 1'b1;
				wb_data = src - rt_val;
			end
			dbg_pkg::op_load: begin
				wb_en   = 1'b1;
				wb_data = dmem[mem_addr];
			end
			// Offset wraps with the 6-bit PC
			dbg_pkg::op_beqz: begin
				if (rd_val == '0)
					pc_next = pc + imm_ext[5:0];
			end
			dbg_pkg::op_halt: pc_next = pc;
			default: ;
		endcase
		// r0 stays zero
		if (instr.rd == 3'd0)
			wb_en = 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// State update
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (ctrl.prog_we)
			imem[ctrl.prog_addr] <= ctrl.prog_word;
	end

	always_ff @(posedge clk) begin
		if (reset || ctrl.core_reset) begin
			pc     <= '0;
			halted <= 1'b0;
			for (int i = 0; i < `DBG_NUM_REGS; i++)
				regs[i] <= '0;
			for (int i = 0; i < `DBG_DMEM_WORDS; i++)
				dmem[i] <= '0;
		end else if (exec) begin
			pc <= pc_next;
			if (wb_en)
				regs[instr.rd] <= wb_data;
			if (instr.op == dbg_pkg::op_store)
				dmem[mem_addr] <= rd_val;
			if (instr.op == dbg_pkg::op_halt)
				halted <= 1'b1;
		end
	end

	// Debug read ports
	assign state.pc       = pc;
	assign state.reg_word = regs[rd.reg_addr];
	assign state.mem_word = dmem[rd.mem_addr];

	no_load_while_run: assert property (
		@(posedge clk) disable iff (reset) ctrl.run_en |-> !ctrl.prog_we
	);

endmodule

// File: source/uart_tx.sv
`timescale 1ns/100ps
`include "dbg_cfg.svh"

module uart_tx (
	input  logic       clk,
	input  logic       reset,
	input  logic       tx_start,
	input  logic [7:0] tx_byte,
	output logic       tx,
	output logic       tx_done
);

	localparam int CLKS  = `DBG_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CLKS) + 1;

	logic [9:0]       frame;
	logic [3:0]       bits_left;
	logic [CNT_W-1:0] cnt;
	logic             busy;

	// Line follows the low end of the frame
	assign tx = frame[0];

	always_ff @(posedge clk) begin
		tx_done <= 1'b0;
		if (reset) begin
			busy      <= 1'b0;
			frame     <= '1;
			bits_left <= '0;
			cnt       <= '0;
		end else if (!busy) begin
			if (tx_start) begin
				// Stop bit, data LSB first, start bit
				frame     <= {1'b1, tx_byte, 1'b0};
				busy      <= 1'b1;
				cnt       <= '0;
				bits_left <= 4'd9;
			end
		end else if (cnt == CNT_W'(CLKS - 1)) begin
			cnt   <= '0;
			frame <= {1'b1, frame[9:1]};
			if (bits_left == 4'd0) begin
				busy    <= 1'b0;
				tx_done <= 1'b1;
			end else begin
				bits_left <= bits_left - 4'd1;
			end
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	start_when_idle: assert property (@(posedge clk) disable iff (reset) tx_start |-> !busy);

endmodule

// File: source/uart_rx.sv
`timescale 1ns/100ps
`include "dbg_cfg.svh"

module uart_rx (
	input  logic       clk,
	input  logic       reset,
	input  logic       rx,
	output logic [7:0] rx_byte,
	output logic       rx_done
);

	localparam int CLKS  = `DBG_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CLKS) + 1;

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} rx_state_e;

	rx_state_e        st;
	logic [1:0]       rx_sync;
	logic             rx_s;
	logic [CNT_W-1:0] cnt;
	logic [2:0]       bit_idx;

	assign rx_s = rx_sync[1];

	always_ff @(posedge clk) begin
		rx_done <= 1'b0;
		if (reset) begin
			st      <= st_idle;
			rx_sync <= 2'b11;
			cnt     <= '0;
			bit_idx <= '0;
		end else begin
			rx_sync <= {rx_sync[0], rx};
			case (st)
				st_idle: begin
					cnt <= '0;
					if (!rx_s)
						st <= st_start;
				end
				// Half a bit in, then confirm the start bit is still low
				st_start: begin
					if (cnt == CNT_W'(CLKS / 2 - 1)) begin
						cnt     <= '0;
						bit_idx <= '0;
						st      <= rx_s ? st_idle : st_data;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_data: begin
					if (cnt == CNT_W'(CLKS - 1)) begin
						cnt     <= '0;
						rx_byte <= {rx_s, rx_byte[7:1]};
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							st <= st_stop;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					if (cnt == CNT_W'(CLKS - 1)) begin
						// Framing error drops the byte
						rx_done <= rx_s;
						st      <= st_idle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	rx_done_single: assert property (@(posedge clk) disable iff (reset) rx_done |=> !rx_done);

endmodule

// File: source/dbg_pkg.sv
package dbg_pkg;

	typedef logic [15:0] word_t;

	typedef enum logic [2:0] {
		op_halt  = 3'd0,
		op_addi  = 3'd1,
		op_add   = 3'd2,
		op_sub   = 3'd3,
		op_load  = 3'd4,
		op_store = 3'd5,
		op_beqz  = 3'd6,
		op_nop   = 3'd7
	} opcode_e;

	// add and sub take rt from imm[2:0]
	typedef struct packed {
		opcode_e           op;
		logic [2:0]        rd;
		logic [2:0]        rs;
		logic signed [6:0] imm;
	} instr_t;

	// Controller to core
	typedef struct packed {
		logic       run_en;
		logic       step;
		logic       core_reset;
		logic       prog_we;
		logic [5:0] prog_addr;
		word_t      prog_word;
	} core_ctrl_t;

	typedef struct packed {
		logic [2:0] reg_addr;
		logic [3:0] mem_addr;
	} state_rd_t;

	typedef struct packed {
		logic [5:0] pc;
		word_t      reg_word;
		word_t      mem_word;
	} state_data_t;

	// Host command bytes, ASCII
	localparam logic [7:0] CMD_PROG = 8'h50;
	localparam logic [7:0] CMD_RUN  = 8'h52;
	localparam logic [7:0] CMD_STEP = 8'h53;
	localparam logic [7:0] CMD_DUMP = 8'h44;

endpackage

// File: source/dbg_cfg.svh
`ifndef DBG_CFG_SVH
`define DBG_CFG_SVH

// Serial bit time in system clocks
// 16 keeps simulation short
// A real baud rate needs a larger value
`define DBG_CLKS_PER_BIT 16

// Core memory sizes
`define DBG_IMEM_WORDS 64
`define DBG_DMEM_WORDS 16
`define DBG_NUM_REGS 8

// Dump layout
// PC byte, then two bytes per register, then two bytes per data word
`define DBG_DUMP_BYTES 49

`endif
